// ==== rename_pkg.sv ====
package rename_pkg;

  // ************************************************************
  // Register numbering
  // ************************************************************

  // Architectural register number, 0 means no register
  typedef logic [4:0] arch_num_t;

  // Rename register number, valid range 32 to 63
  typedef logic [5:0] ren_num_t;

  localparam int NUM_ARCH = 32;
  localparam int NUM_REN  = 32;  // Rename registers, also the free list depth

  // ************************************************************
  // Speculation control
  // ************************************************************

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SPEC  = 2'd1,
    FLUSH = 2'd2
  } ctrl_state_t;

endpackage

// ==== data_pkg.sv ====
package data_pkg;

  typedef logic [31:0] word_t;

  // Rename number view of an operand word
  typedef struct packed {
    logic [25:0]          pad;
    rename_pkg::ren_num_t num;
  } wait_on_t;

  // ************************************************************
  // Operand word
  // ************************************************************

  // The ready flag beside the operand selects the view
  typedef union packed {
    word_t    value;    // Ready operand
    wait_on_t wait_on;  // Producer still outstanding
  } operand_u;

endpackage

// ==== rename_ifs.sv ====
`timescale 1ns/1ps

// Free list traffic between the map table and the queue
interface free_if;
  import rename_pkg::*;

  logic       alloc;        // Pop the head
  ren_num_t   alloc_num;    // Queue head
  logic       release_en;   // Push release_num
  ren_num_t   release_num;
  logic       empty;
  logic [5:0] count;

  modport list (
    input  alloc, release_en, release_num,
    output alloc_num, empty, count
  );

  modport map_tbl (
    output alloc, release_en, release_num,
    input  alloc_num, empty, count
  );

endinterface

// Speculation control broadcast from the FSM
interface flush_if;
  import rename_pkg::*;

  ctrl_state_t state;
  logic        clear_tag;   // One cycle pulse
  logic        delete_tag;  // One cycle pulse
  logic        scan_en;
  ren_num_t    scan_num;

  modport ctrl (output state, clear_tag, delete_tag, scan_en, scan_num);

  modport map_tbl (input state, clear_tag, delete_tag, scan_en, scan_num);

  modport regs (input state, clear_tag, scan_en, scan_num);

endinterface

// ==== rename_ctrl_fsm.sv ====
`timescale 1ns/1ps

module rename_ctrl_fsm (
  input  logic  global_bus,
  input  logic  rst_n,
  input  logic  spec_begin,
  input  logic  branch_ok,
  input  logic  branch_bad,
  output logic  busy,
  flush_if.ctrl flush
);
  import rename_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic [4:0]  scan_idx_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (spec_begin) state_d = SPEC;
      SPEC: begin
        if (branch_bad) state_d = FLUSH;
        else if (branch_ok) state_d = IDLE;
      end
      FLUSH: if (scan_idx_q == 5'd31) state_d = IDLE;  // Last scan step
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      scan_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FLUSH) scan_idx_q <= scan_idx_q + 5'd1;  // Wraps to 0 on exit
    end
  end

  assign busy             = (state_q == FLUSH);
  assign flush.state      = state_q;
  assign flush.clear_tag  = (state_q == SPEC) && branch_ok && !branch_bad;
  assign flush.delete_tag = (state_q == SPEC) && branch_bad;
  assign flush.scan_en    = busy;
  assign flush.scan_num   = ren_num_t'(NUM_REN) + ren_num_t'(scan_idx_q);

  // ************************************************************
  // Checks
  // ************************************************************

  a_branch_in_spec: assert property (@(posedge global_bus) disable iff (!rst_n)
    (branch_ok || branch_bad) |-> (state_q == SPEC));

  a_branch_exclusive: assert property (@(posedge global_bus) disable iff (!rst_n)
    !(branch_ok && branch_bad));

endmodule

// ==== rename_free_list.sv ====
`timescale 1ns/1ps

module rename_free_list (
  input logic  global_bus,
  input logic  rst_n,
  free_if.list fl
);
  import rename_pkg::*;

  ren_num_t   queue_q [NUM_REN];
  logic [4:0] head_q;
  logic [4:0] tail_q;
  logic [5:0] count_q;

  assign fl.alloc_num = queue_q[head_q];
  assign fl.empty     = (count_q == 6'd0);
  assign fl.count     = count_q;

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      // Every rename register starts free, in ascending order
      for (int i = 0; i < NUM_REN; i++) begin
        queue_q[i] <= ren_num_t'(NUM_REN + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= 6'(NUM_REN);
    end else begin
      if (fl.alloc) head_q <= head_q + 5'd1;
      if (fl.release_en) begin
        queue_q[tail_q] <= fl.release_num;
        tail_q          <= tail_q + 5'd1;
      end
      case ({fl.alloc, fl.release_en})
        2'b10:   count_q <= count_q - 6'd1;
        2'b01:   count_q <= count_q + 6'd1;
        default: count_q <= count_q;  // Idle, or pop and push together
      endcase
    end
  end

  // ************************************************************
  // Checks
  // ************************************************************

  a_no_pop_empty: assert property (@(posedge global_bus) disable iff (!rst_n)
    fl.alloc |-> !fl.empty);

  a_no_push_full: assert property (@(posedge global_bus) disable iff (!rst_n)
    fl.release_en |-> (count_q < 6'(NUM_REN)));

endmodule

// ==== rename_map_table.sv ====
`timescale 1ns/1ps

module rename_map_table (
  input  logic                  global_bus,
  input  logic                  rst_n,
  input  logic                  rename,
  input  rename_pkg::arch_num_t rename_rd,
  input  logic                  commit_en,
  input  rename_pkg::arch_num_t commit_arn,
  input  rename_pkg::ren_num_t  commit_rrn,
  input  data_pkg::word_t       commit_result,
  input  rename_pkg::arch_num_t src_1,
  input  rename_pkg::arch_num_t src_2,
  input  logic                  scan_hit,
  output rename_pkg::ren_num_t  map_1,
  output rename_pkg::ren_num_t  map_2,
  output data_pkg::word_t       arch_val_1,
  output data_pkg::word_t       arch_val_2,
  free_if.map_tbl               fl,
  flush_if.map_tbl              flush
);
  import rename_pkg::*;
  import data_pkg::*;

  word_t               arch_val_q [NUM_ARCH];
  ren_num_t            map_q      [NUM_ARCH];
  ren_num_t            map_d      [NUM_ARCH];
  ren_num_t            saved_q    [NUM_ARCH];
  ren_num_t            saved_d    [NUM_ARCH];
  logic [NUM_ARCH-1:0] tag_q;
  logic [NUM_ARCH-1:0] tag_d;
  logic                take;
  logic                spec;

  assign take = rename && (rename_rd != '0) && !fl.empty && (flush.state != FLUSH);
  assign spec = (flush.state == SPEC) && !flush.clear_tag;

  assign fl.alloc       = take;
  assign fl.release_en  = commit_en || (flush.scan_en && scan_hit);
  assign fl.release_num = commit_en ? commit_rrn : flush.scan_num;  // Commit or scan

  assign map_1      = map_q[src_1];
  assign map_2      = map_q[src_2];
  assign arch_val_1 = arch_val_q[src_1];
  assign arch_val_2 = arch_val_q[src_2];

  always_comb begin
    map_d   = map_q;
    saved_d = saved_q;
    tag_d   = tag_q;
    if (commit_en) begin
      if (map_d[commit_arn] == commit_rrn) map_d[commit_arn] = '0;
      if (saved_d[commit_arn] == commit_rrn) saved_d[commit_arn] = '0;
    end
    if (flush.delete_tag) begin
      for (int a = 1; a < NUM_ARCH; a++) begin
        if (tag_q[a]) begin
          map_d[a]   = saved_d[a];  // Back to the pre-branch mapping
          saved_d[a] = '0;
          tag_d[a]   = 1'b0;
        end
      end
    end else if (flush.clear_tag) begin
      tag_d = '0;
    end
    // A rename in the delete cycle is wrong path and leaves the map alone
    if (take && !flush.delete_tag) begin
      if (spec && !tag_q[rename_rd]) saved_d[rename_rd] = map_d[rename_rd];
      map_d[rename_rd] = fl.alloc_num;
      tag_d[rename_rd] = spec;
    end
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < NUM_ARCH; a++) begin
        arch_val_q[a] <= '0;
        map_q[a]      <= '0;
        saved_q[a]    <= '0;
      end
      tag_q <= '0;
    end else begin
      map_q   <= map_d;
      saved_q <= saved_d;
      tag_q   <= tag_d;
      if (commit_en && (commit_arn != '0)) arch_val_q[commit_arn] <= commit_result;
    end
  end

  a_no_commit_in_flush: assert property (@(posedge global_bus) disable iff (!rst_n)
    commit_en |-> (flush.state != FLUSH));

endmodule

// ==== rename_reg_file.sv ====
`timescale 1ns/1ps

module rename_reg_file (
  input  logic                 global_bus,
  input  logic                 rst_n,
  input  logic                 alloc,
  input  rename_pkg::ren_num_t alloc_num,
  input  logic                 wb_en,
  input  rename_pkg::ren_num_t wb_rrn,
  input  data_pkg::word_t      wb_result,
  input  logic                 commit_en,
  input  rename_pkg::ren_num_t commit_rrn,
  input  rename_pkg::ren_num_t map_1,
  input  rename_pkg::ren_num_t map_2,
  output data_pkg::word_t      ren_val_1,
  output data_pkg::word_t      ren_val_2,
  output logic                 ren_valid_1,
  output logic                 ren_valid_2,
  output logic                 scan_hit,
  flush_if.regs                flush
);
  import rename_pkg::*;
  import data_pkg::*;

  word_t              val_q [NUM_REN];
  logic [NUM_REN-1:0] valid_q;
  logic [NUM_REN-1:0] tag_q;
  logic [4:0]         scan_idx;
  logic               spec;

  // Rename numbers 32 to 63 index the arrays by their low five bits
  assign scan_idx    = flush.scan_num[4:0];
  assign scan_hit    = flush.scan_en && tag_q[scan_idx];
  assign spec        = (flush.state == SPEC) && !flush.clear_tag;
  assign ren_val_1   = val_q[map_1[4:0]];
  assign ren_val_2   = val_q[map_2[4:0]];
  assign ren_valid_1 = valid_q[map_1[4:0]];
  assign ren_valid_2 = valid_q[map_2[4:0]];

  always_ff @(posedge global_bus) begin
    if (wb_en) val_q[wb_rrn[4:0]] <= wb_result;
  end

  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      tag_q   <= '0;
    end else begin
      if (flush.clear_tag) tag_q <= '0;
      if (wb_en) valid_q[wb_rrn[4:0]] <= 1'b1;
      if (alloc) begin
        valid_q[alloc_num[4:0]] <= 1'b0;
        tag_q[alloc_num[4:0]]   <= spec;  // Tagged while speculating
      end
      if (commit_en) begin
        valid_q[commit_rrn[4:0]] <= 1'b0;
        tag_q[commit_rrn[4:0]]   <= 1'b0;
      end
      if (scan_hit) begin
        valid_q[scan_idx] <= 1'b0;
        tag_q[scan_idx]   <= 1'b0;
      end
    end
  end

  a_wb_in_range: assert property (@(posedge global_bus) disable iff (!rst_n)
    wb_en |-> (wb_rrn >= ren_num_t'(NUM_REN)));

endmodule

// ==== operand_lookup.sv ====
`timescale 1ns/1ps

module operand_lookup (
  input  rename_pkg::ren_num_t map_1,
  input  rename_pkg::ren_num_t map_2,
  input  data_pkg::word_t      arch_val_1,
  input  data_pkg::word_t      arch_val_2,
  input  data_pkg::word_t      ren_val_1,
  input  data_pkg::word_t      ren_val_2,
  input  logic                 ren_valid_1,
  input  logic                 ren_valid_2,
  output data_pkg::operand_u   op_1,
  output data_pkg::operand_u   op_2,
  output logic                 op_1_ready,
  output logic                 op_2_ready
);
  import rename_pkg::*;
  import data_pkg::*;

  function automatic operand_u pick(input ren_num_t map, input word_t arch_val,
                                    input word_t ren_val, input logic ren_valid,
                                    output logic ready);
    operand_u op;
    if (map == '0) begin          // Not renamed
      op.value = arch_val;
      ready    = 1'b1;
    end else if (ren_valid) begin
      op.value = ren_val;
      ready    = 1'b1;
    end else begin
      op.wait_on.pad = '0;
      op.wait_on.num = map;       // Wait for this producer
      ready          = 1'b0;
    end
    return op;
  endfunction

  always_comb begin
    op_1 = pick(map_1, arch_val_1, ren_val_1, ren_valid_1, op_1_ready);
    op_2 = pick(map_2, arch_val_2, ren_val_2, ren_valid_2, op_2_ready);
  end

endmodule

// ==== rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
  input  logic                  global_bus,
  input  logic                  rst_n,
  input  logic                  rename,
  input  rename_pkg::arch_num_t rename_rd,
  input  logic                  spec_begin,
  input  logic                  branch_ok,
  input  logic                  branch_bad,
  input  logic                  wb_en,
  input  rename_pkg::ren_num_t  wb_rrn,
  input  data_pkg::word_t       wb_result,
  input  logic                  commit_en,
  input  rename_pkg::arch_num_t commit_arn,
  input  rename_pkg::ren_num_t  commit_rrn,
  input  data_pkg::word_t       commit_result,
  input  rename_pkg::arch_num_t src_1,
  input  rename_pkg::arch_num_t src_2,
  output rename_pkg::ren_num_t  rename_num,
  output data_pkg::operand_u    op_1,
  output logic                  op_1_ready,
  output data_pkg::operand_u    op_2,
  output logic                  op_2_ready,
  output logic                  busy,
  output logic                  free_empty,
  output logic [5:0]            free_count
);
  import rename_pkg::*;
  import data_pkg::*;

  free_if  fl ();
  flush_if flush ();

  ren_num_t map_1, map_2;
  word_t    arch_val_1, arch_val_2;
  word_t    ren_val_1, ren_val_2;
  logic     ren_valid_1, ren_valid_2;
  logic     scan_hit;

  assign rename_num = fl.alloc_num;
  assign free_empty = fl.empty;
  assign free_count = fl.count;

  rename_ctrl_fsm u_ctrl (.global_bus, .rst_n, .spec_begin, .branch_ok, .branch_bad,
                          .busy, .flush);

  rename_free_list u_free (.global_bus, .rst_n, .fl);

  rename_map_table u_map (.global_bus, .rst_n, .rename, .rename_rd, .commit_en,
                          .commit_arn, .commit_rrn, .commit_result, .src_1, .src_2,
                          .scan_hit, .map_1, .map_2, .arch_val_1, .arch_val_2,
                          .fl, .flush);

  rename_reg_file u_regs (.global_bus, .rst_n, .alloc(fl.alloc), .alloc_num(fl.alloc_num),
                          .wb_en, .wb_rrn, .wb_result, .commit_en, .commit_rrn,
                          .map_1, .map_2, .ren_val_1, .ren_val_2, .ren_valid_1,
                          .ren_valid_2, .scan_hit, .flush);

  operand_lookup u_lookup (.map_1, .map_2, .arch_val_1, .arch_val_2, .ren_val_1,
                           .ren_val_2, .ren_valid_1, .ren_valid_2, .op_1, .op_2,
                           .op_1_ready, .op_2_ready);

endmodule

// ==== tb_rename_model.svh ====
`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

// ************************************************************
// Reference model, stepped once per clock edge
// ************************************************************

ctrl_state_t m_state;
logic [4:0]  m_scan;
ren_num_t    m_free [$];               // Free numbers, head first
ren_num_t    m_map [32], m_saved [32];
word_t       m_arch [32], m_rval [32];
logic [31:0] m_tag;                    // Arch registers renamed while speculating
logic [31:0] m_rvalid, m_rtag;         // Rename registers, indexed by number - 32
ren_num_t    pend_rrn [$];             // Renames not yet committed, oldest first
arch_num_t   pend_arn [$];

task automatic model_reset();
  m_state  = IDLE;
  m_scan   = '0;
  m_tag    = '0;
  m_rvalid = '0;
  m_rtag   = '0;
  m_map    = '{default: '0};
  m_saved  = '{default: '0};
  m_arch   = '{default: '0};
  for (int i = 0; i < 32; i++) m_free.push_back(ren_num_t'(32 + i));
endtask

task automatic model_step();
  logic     take;
  logic     spec;
  logic     del;
  ren_num_t head;
  take = rename && (rename_rd != '0) && (m_free.size() > 0) && (m_state != FLUSH);
  spec = (m_state == SPEC) && !branch_ok;
  del  = (m_state == SPEC) && branch_bad;
  head = take ? m_free[0] : '0;
  if (commit_en) begin
    if (m_map[commit_arn] == commit_rrn) m_map[commit_arn] = '0;
    if (m_saved[commit_arn] == commit_rrn) m_saved[commit_arn] = '0;
    m_arch[commit_arn]        = commit_result;
    m_rvalid[commit_rrn[4:0]] = 1'b0;
    m_free.push_back(commit_rrn);
    pend_rrn.delete(0);
    pend_arn.delete(0);
  end
  if (del) begin
    for (int a = 1; a < 32; a++) begin
      if (m_tag[a]) m_map[a] = m_saved[a];  // Back to the pre-branch mapping
    end
    m_tag = '0;
    for (int i = pend_rrn.size() - 1; i >= 0; i--) begin
      if (m_rtag[pend_rrn[i][4:0]]) begin   // Wrong path, never commits
        pend_rrn.delete(i);
        pend_arn.delete(i);
      end
    end
  end else if (m_state == SPEC && branch_ok) begin
    m_tag  = '0;
    m_rtag = '0;
  end
  if (wb_en) begin
    m_rval[wb_rrn[4:0]]   = wb_result;
    m_rvalid[wb_rrn[4:0]] = 1'b1;
  end
  if (take) begin
    m_free.delete(0);
    m_rvalid[head[4:0]] = 1'b0;
    m_rtag[head[4:0]]   = spec;
    if (!del) begin
      if (spec && !m_tag[rename_rd]) m_saved[rename_rd] = m_map[rename_rd];
      m_map[rename_rd] = head;
      m_tag[rename_rd] = spec;
      pend_rrn.push_back(head);
      pend_arn.push_back(rename_rd);
    end
  end
  case (m_state)
    IDLE: if (spec_begin) m_state = SPEC;
    SPEC: begin
      if (del) m_state = FLUSH;
      else if (branch_ok) m_state = IDLE;
    end
    default: begin
      if (m_rtag[m_scan]) begin
        m_free.push_back({1'b1, m_scan});  // Number 32 + k
        m_rvalid[m_scan] = 1'b0;
        m_rtag[m_scan]   = 1'b0;
      end
      if (m_scan == 5'd31) m_state = IDLE;
      m_scan = m_scan + 5'd1;
    end
  endcase
endtask

// Ready flag on top of the operand word
function automatic logic [32:0] expect_operand(input arch_num_t src);
  ren_num_t r;
  r = m_map[src];
  if (r == '0) return {1'b1, m_arch[src]};
  if (m_rvalid[r[4:0]]) return {1'b1, m_rval[r[4:0]]};
  return {1'b0, 26'd0, r};
endfunction

`endif

// ==== tb_rename_unit.sv ====
`timescale 1ns/1ps

module tb_rename_unit;
  import rename_pkg::*;
  import data_pkg::*;

  localparam int NUM_CYCLES = 3000;
  localparam int TIMEOUT    = NUM_CYCLES + 1000;  // Reset, the last flush and slack

  logic       global_bus, rst_n, rename, spec_begin, branch_ok, branch_bad;
  logic       wb_en, commit_en, op_1_ready, op_2_ready, busy, free_empty;
  logic [5:0] free_count;
  arch_num_t  rename_rd, commit_arn, src_1, src_2;
  arch_num_t  last_rd;  // Port 2 looks at the newest rename
  ren_num_t   wb_rrn, commit_rrn, rename_num;
  word_t      wb_result, commit_result;
  operand_u   op_1, op_2;
  integer     seed = 89485;
  int         cycles = 0;

  `include "tb_rename_model.svh"

  rename_unit dut_i (.*);

  initial begin
    global_bus = 1'b0;
    forever #50 global_bus = ~global_bus;
  end

  always @(posedge global_bus) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) stop_run("Timeout, the test did not reach its end");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [32:0] got,
                            input logic [32:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // ************************************************************
  // Stimulus and checks
  // ************************************************************

  task automatic drive_inputs(input bit active);
    int pick;
    rename     = active && (($random(seed) & 1) == 1);
    rename_rd  = arch_num_t'($random(seed));
    src_1      = arch_num_t'($random(seed));
    src_2      = last_rd;
    if (rename) last_rd = rename_rd;
    pick       = $random(seed) & 15;
    spec_begin = active && m_state == IDLE && pick == 0;
    branch_ok  = active && m_state == SPEC && pick == 1;
    branch_bad = active && m_state == SPEC && pick == 2;
    wb_en = 1'b0;
    if (active && pend_rrn.size() > 0) begin
      pick      = int'($unsigned($random(seed)) % pend_rrn.size());
      wb_rrn    = pend_rrn[pick];
      wb_result = $random(seed);
      wb_en     = !m_rvalid[wb_rrn[4:0]];
    end
    commit_en = 1'b0;
    if (active && m_state != FLUSH && pend_rrn.size() > 0) begin
      commit_rrn    = pend_rrn[0];
      commit_arn    = pend_arn[0];
      commit_result = m_rval[commit_rrn[4:0]];
      // Oldest rename retires once written back and off the speculative path
      commit_en     = m_rvalid[commit_rrn[4:0]] && !m_rtag[commit_rrn[4:0]]
                      && (($random(seed) & 1) == 1);
    end
  endtask

  task automatic check_outputs();
    check_word("op_1", {op_1_ready, op_1}, expect_operand(src_1));
    check_word("op_2", {op_2_ready, op_2}, expect_operand(src_2));
    check_word("busy", 33'(busy), 33'(m_state == FLUSH));
    check_word("free_count", 33'(free_count), 33'(m_free.size()));
    check_word("free_empty", 33'(free_empty), 33'(m_free.size() == 0));
    if (m_free.size() > 0) check_word("rename_num", 33'(rename_num), 33'(m_free[0]));
  endtask

  task automatic run_cycle(input bit active);
    @(posedge global_bus);
    model_step();
    #1;
    drive_inputs(active);
    @(negedge global_bus);
    check_outputs();
  endtask

  initial begin
    rst_n         = 1'b0;
    last_rd       = '0;
    wb_rrn        = 6'd32;
    commit_rrn    = 6'd32;
    commit_arn    = '0;
    wb_result     = '0;
    commit_result = '0;
    model_reset();
    drive_inputs(1'b0);
    repeat (3) @(posedge global_bus);
    #1 rst_n = 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) run_cycle(1'b1);
    while (busy) run_cycle(1'b0);  // Let the last flush run out
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
rename_pkg.sv
data_pkg.sv
rename_ifs.sv
rename_ctrl_fsm.sv
rename_free_list.sv
rename_map_table.sv
rename_reg_file.sv
operand_lookup.sv
rename_unit.sv
tb_rename_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_rename_unit \
  -Mdir obj_dir -o tb_rename_unit

./obj_dir/tb_rename_unit | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
